/* rtl/rename_pkg.sv */
////////////////////////////////////////
// Shared widths, tag types and lane structs
// for the register renaming core.
// Modules import it in their bodies and use
// scoped names in their port lists.
////////////////////////////////////////

package rename_pkg;

    // Default bundle width
    localparam int NUM_LANES = 2;

    // Register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    localparam int ARCH_REG_W = $clog2(ARCH_REGS);
    localparam int PHYS_TAG_W = $clog2(PHYS_REGS);

    // Architectural register index
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // Physical register tag
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;

    // One bit per physical register
    typedef logic [PHYS_REGS-1:0] phys_mask_t;

    // Count of physical registers, 0 to PHYS_REGS
    typedef logic [$clog2(PHYS_REGS+1)-1:0] phys_count_t;

    // One lane of the rename request
    typedef struct packed {
        logic      valid;
        logic      uses_rd;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } rename_req_t;

    // One lane of the rename result
    typedef struct packed {
        logic      valid;
        logic      has_dest;
        phys_tag_t prs1;
        phys_tag_t prs2;
        phys_tag_t prd;
        phys_tag_t old_prd;
    } rename_resp_t;

    // One retiring instruction
    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        phys_tag_t prd;
    } retire_t;

endpackage

/* rtl/spec_map_table.sv */
////////////////////////////////////////
// Speculative map table.
// Gives combinational source and old dest
// tags, takes the bundle's new mappings and
// is overwritten from the architected map
// when a mispredict is signalled.
////////////////////////////////////////

`timescale 1ns/1ps

module spec_map_table #(
    parameter int NUM_LANES = rename_pkg::NUM_LANES
) (
    input  logic                                              clock,
    input  logic                                              rst_n,
    // Read ports, index 0 is rs1 and index 1 is rs2
    input  rename_pkg::arch_reg_t [NUM_LANES-1:0][1:0]        src_regs,
    input  rename_pkg::arch_reg_t [NUM_LANES-1:0]             dst_regs,
    // Bundle writes
    input  logic                  [NUM_LANES-1:0]             wr_en,
    input  rename_pkg::phys_tag_t [NUM_LANES-1:0]             wr_tags,
    // Recovery
    input  logic                                              restore_en,
    input  rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] restore_map,
    // Read results
    output rename_pkg::phys_tag_t [NUM_LANES-1:0][1:0]        src_tags,
    output rename_pkg::phys_tag_t [NUM_LANES-1:0]             dst_old_tags
);

    import rename_pkg::*;

    phys_tag_t [ARCH_REGS-1:0] map_q;
    phys_tag_t [ARCH_REGS-1:0] map_d;

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Table state only; same-bundle bypass lives in the bundle logic
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            src_tags[k][0]  = map_q[src_regs[k][0]];
            src_tags[k][1]  = map_q[src_regs[k][1]];
            dst_old_tags[k] = map_q[dst_regs[k]];
        end
    end

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        map_d = map_q;
        // Lane order, so the youngest writer of an rd wins
        for (int k = 0; k < NUM_LANES; k++) begin
            if (wr_en[k]) begin
                map_d[dst_regs[k]] = wr_tags[k];
            end
        end
        // Whole table back to committed state
        if (restore_en) begin
            map_d = restore_map;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // Identity map out of reset
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else begin
            map_q <= map_d;
        end
    end

endmodule

/* rtl/free_list.sv */
////////////////////////////////////////
// Free list of physical tags as a bitmap.
// Offers the lowest free tags, one per lane,
// with the free count. Allocations clear
// bits, retire frees set them, and restore
// loads the whole bitmap at once.
////////////////////////////////////////

`timescale 1ns/1ps

module free_list #(
    parameter int NUM_LANES = rename_pkg::NUM_LANES
) (
    input  logic                                  clock,
    input  logic                                  rst_n,
    // Number of offered tags taken this cycle
    input  logic [$clog2(NUM_LANES+1)-1:0]        alloc_count,
    // Tags released by retire
    input  rename_pkg::phys_mask_t                free_mask,
    // Recovery
    input  logic                                  restore_en,
    input  rename_pkg::phys_mask_t                restore_mask,
    // Lowest free tags, lane 0 gets the lowest
    output rename_pkg::phys_tag_t [NUM_LANES-1:0] free_tags,
    output logic                  [NUM_LANES-1:0] free_tag_valid,
    output rename_pkg::phys_count_t               free_count
);

    import rename_pkg::*;

    // Tags above the architected range start out free
    localparam phys_mask_t RESET_FREE = {{(PHYS_REGS-ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};

    phys_mask_t free_q;
    phys_mask_t free_d;

    ////////////////////////////////////////
    // Priority search and popcount
    ////////////////////////////////////////

    always_comb begin
        int found;
        found          = 0;
        free_tags      = '0;
        free_tag_valid = '0;
        // Low to high, first NUM_LANES hits are offered
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (free_q[i]) begin
                if (found < NUM_LANES) begin
                    free_tags[found]      = phys_tag_t'(i);
                    free_tag_valid[found] = 1'b1;
                end
                found++;
            end
        end
        // Every free bit counts, not just the offered ones
        free_count = phys_count_t'(found);
    end

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        free_d = free_q;
        // Allocation always takes from the front of the offer
        for (int k = 0; k < NUM_LANES; k++) begin
            if (k < alloc_count && free_tag_valid[k]) begin
                free_d[free_tags[k]] = 1'b0;
            end
        end
        // Retired tags usable from next cycle
        free_d = free_d | free_mask;
        // Recovery overrides both
        if (restore_en) begin
            free_d = restore_mask;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            free_q <= RESET_FREE;
        end else begin
            free_q <= free_d;
        end
    end

endmodule

/* rtl/rename_bundle.sv */
////////////////////////////////////////
// Bundle rename logic.
// Picks the lanes that need a new tag,
// raises stall when too few are free, hands
// tags out in lane order, bypasses within
// the bundle and registers the results.
////////////////////////////////////////

`timescale 1ns/1ps

module rename_bundle #(
    parameter int NUM_LANES = rename_pkg::NUM_LANES
) (
    input  logic                                         clock,
    input  logic                                         rst_n,
    input  rename_pkg::rename_req_t  [NUM_LANES-1:0]     rename_reqs,
    // From the speculative map
    input  rename_pkg::phys_tag_t    [NUM_LANES-1:0][1:0] src_tags,
    input  rename_pkg::phys_tag_t    [NUM_LANES-1:0]     dst_old_tags,
    // From the free list
    input  rename_pkg::phys_tag_t    [NUM_LANES-1:0]     free_tags,
    input  logic                     [NUM_LANES-1:0]     free_tag_valid,
    input  rename_pkg::phys_count_t                      free_count,
    input  logic                                         mispredict,
    // To the speculative map
    output rename_pkg::arch_reg_t    [NUM_LANES-1:0][1:0] src_regs,
    output rename_pkg::arch_reg_t    [NUM_LANES-1:0]     dst_regs,
    output logic                     [NUM_LANES-1:0]     wr_en,
    output rename_pkg::phys_tag_t    [NUM_LANES-1:0]     wr_tags,
    // To the free list
    output logic [$clog2(NUM_LANES+1)-1:0]               alloc_count,
    // Registered results
    output rename_pkg::rename_resp_t [NUM_LANES-1:0]     rename_resps,
    output logic                                         stall
);

    import rename_pkg::*;

    localparam int CNT_W = $clog2(NUM_LANES+1);

    logic         [NUM_LANES-1:0] need;
    logic         [CNT_W-1:0]     need_count;
    logic                         go;
    phys_tag_t    [NUM_LANES-1:0] new_tags;
    logic         [NUM_LANES-1:0] tag_ok;
    rename_resp_t [NUM_LANES-1:0] resp_d;
    rename_resp_t [NUM_LANES-1:0] resp_q;

    ////////////////////////////////////////
    // Destination need and tag assignment
    ////////////////////////////////////////

    always_comb begin
        int idx;
        idx = 0;
        for (int k = 0; k < NUM_LANES; k++) begin
            // x0 is never renamed
            need[k] = rename_reqs[k].valid && rename_reqs[k].uses_rd &&
                      (rename_reqs[k].rd != '0);
            // idx counts needing lanes before this one
            new_tags[k] = free_tags[idx];
            tag_ok[k]   = free_tag_valid[idx];
            if (need[k]) begin
                idx++;
            end
            src_regs[k][0] = rename_reqs[k].rs1;
            src_regs[k][1] = rename_reqs[k].rs2;
            dst_regs[k]    = rename_reqs[k].rd;
        end
        need_count = CNT_W'(idx);
    end

    // All or nothing for the bundle
    assign stall = phys_count_t'(need_count) > free_count;
    assign go    = !stall && !mispredict;

    assign alloc_count = go ? need_count : '0;
    assign wr_tags     = new_tags;

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            wr_en[k] = go && need[k] && tag_ok[k];
        end
    end

    ////////////////////////////////////////
    // Intra-bundle bypass
    ////////////////////////////////////////

    always_comb begin
        phys_tag_t prs1;
        phys_tag_t prs2;
        phys_tag_t old_tag;
        for (int k = 0; k < NUM_LANES; k++) begin
            prs1    = src_tags[k][0];
            prs2    = src_tags[k][1];
            old_tag = dst_old_tags[k];
            // Ascending scan leaves the newest earlier writer
            for (int j = 0; j < k; j++) begin
                if (need[j]) begin
                    if (rename_reqs[j].rd == rename_reqs[k].rs1) prs1 = new_tags[j];
                    if (rename_reqs[j].rd == rename_reqs[k].rs2) prs2 = new_tags[j];
                    if (rename_reqs[j].rd == rename_reqs[k].rd)  old_tag = new_tags[j];
                end
            end
            resp_d[k].valid    = rename_reqs[k].valid && go;
            resp_d[k].has_dest = need[k];
            resp_d[k].prs1     = prs1;
            resp_d[k].prs2     = prs2;
            // No destination reports tag 0 for both
            resp_d[k].prd      = need[k] ? new_tags[k] : '0;
            resp_d[k].old_prd  = need[k] ? old_tag : '0;
        end
    end

    // One cycle of latency to the outputs
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                resp_q[k].valid <= 1'b0;
            end
        end else begin
            resp_q <= resp_d;
        end
    end

    assign rename_resps = resp_q;

endmodule

/* rtl/arch_map_table.sv */
////////////////////////////////////////
// Architected (committed) map table.
// Takes retire writes, reports the tags
// they replace for freeing, and offers its
// next state plus the unused-tag mask for
// mispredict recovery.
////////////////////////////////////////

`timescale 1ns/1ps

module arch_map_table #(
    parameter int NUM_LANES = rename_pkg::NUM_LANES
) (
    input  logic                                              clock,
    input  logic                                              rst_n,
    input  rename_pkg::retire_t   [NUM_LANES-1:0]             retires,
    // Table including this cycle's retires
    output rename_pkg::phys_tag_t [rename_pkg::ARCH_REGS-1:0] next_map,
    // Tags replaced by retiring lanes
    output rename_pkg::phys_mask_t                            free_mask,
    // Tags next_map does not hold
    output rename_pkg::phys_mask_t                            restore_mask
);

    import rename_pkg::*;

    phys_tag_t [ARCH_REGS-1:0] map_q;

    ////////////////////////////////////////
    // Retire update
    ////////////////////////////////////////

    always_comb begin
        next_map  = map_q;
        free_mask = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (retires[k].valid && retires[k].rd != '0) begin
                // next_map already has earlier lanes applied
                free_mask[next_map[retires[k].rd]] = 1'b1;
                next_map[retires[k].rd]            = retires[k].prd;
            end
        end
    end

    // Everything starts free, then mapped tags are struck out
    always_comb begin
        restore_mask = '1;
        for (int i = 0; i < ARCH_REGS; i++) begin
            restore_mask[next_map[i]] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else begin
            map_q <= next_map;
        end
    end

endmodule

/* rtl/rename_core.sv */
////////////////////////////////////////
// Register renaming core, top level.
// Speculative map and free list feed the
// bundle logic; the architected map drives
// retire frees and mispredict recovery.
////////////////////////////////////////

`timescale 1ns/1ps

module rename_core #(
    parameter int NUM_LANES = rename_pkg::NUM_LANES
) (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  rename_pkg::rename_req_t  [NUM_LANES-1:0] rename_reqs,
    input  rename_pkg::retire_t      [NUM_LANES-1:0] retires,
    input  logic                                     mispredict,
    output rename_pkg::rename_resp_t [NUM_LANES-1:0] rename_resps,
    output logic                                     stall
);

    import rename_pkg::*;

    // Map table ports
    arch_reg_t [NUM_LANES-1:0][1:0] src_regs;
    arch_reg_t [NUM_LANES-1:0]      dst_regs;
    phys_tag_t [NUM_LANES-1:0][1:0] src_tags;
    phys_tag_t [NUM_LANES-1:0]      dst_old_tags;
    logic      [NUM_LANES-1:0]      wr_en;
    phys_tag_t [NUM_LANES-1:0]      wr_tags;

    // Free list ports
    phys_tag_t   [NUM_LANES-1:0]         free_tags;
    logic        [NUM_LANES-1:0]         free_tag_valid;
    phys_count_t                         free_count;
    logic        [$clog2(NUM_LANES+1)-1:0] alloc_count;

    // Recovery and retire
    phys_tag_t  [ARCH_REGS-1:0] arch_next_map;
    phys_mask_t                 retire_free_mask;
    phys_mask_t                 restore_mask;

    spec_map_table #(.NUM_LANES(NUM_LANES)) spec_map_table_0 (
        .clock       (clock),
        .rst_n       (rst_n),
        .src_regs    (src_regs),
        .dst_regs    (dst_regs),
        .wr_en       (wr_en),
        .wr_tags     (wr_tags),
        .restore_en  (mispredict),
        .restore_map (arch_next_map),
        .src_tags    (src_tags),
        .dst_old_tags(dst_old_tags)
    );

    free_list #(.NUM_LANES(NUM_LANES)) free_list_0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .alloc_count   (alloc_count),
        .free_mask     (retire_free_mask),
        .restore_en    (mispredict),
        .restore_mask  (restore_mask),
        .free_tags     (free_tags),
        .free_tag_valid(free_tag_valid),
        .free_count    (free_count)
    );

    rename_bundle #(.NUM_LANES(NUM_LANES)) rename_bundle_0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .rename_reqs   (rename_reqs),
        .src_tags      (src_tags),
        .dst_old_tags  (dst_old_tags),
        .free_tags     (free_tags),
        .free_tag_valid(free_tag_valid),
        .free_count    (free_count),
        .mispredict    (mispredict),
        .src_regs      (src_regs),
        .dst_regs      (dst_regs),
        .wr_en         (wr_en),
        .wr_tags       (wr_tags),
        .alloc_count   (alloc_count),
        .rename_resps  (rename_resps),
        .stall         (stall)
    );

    arch_map_table #(.NUM_LANES(NUM_LANES)) arch_map_table_0 (
        .clock       (clock),
        .rst_n       (rst_n),
        .retires     (retires),
        .next_map    (arch_next_map),
        .free_mask   (retire_free_mask),
        .restore_mask(restore_mask)
    );

endmodule

/* test/rename_core_tb.sv */
////////////////////////////////////////
// Testbench for the register renaming core.
// Reads one line per cycle from the stim
// file, drives it on the falling edge and
// checks stall and the one-cycle-late
// responses. Prints one line per test.
////////////////////////////////////////

`timescale 1ns/1ps

module rename_core_tb;

    import rename_pkg::*;

    // Stim file layout, fixed at two lanes
    localparam int LANES        = 2;
    localparam int NUM_FIELDS   = 30;
    localparam int RESET_CYCLES = 5;
    localparam int PERIOD       = 8;

    logic                     clock;
    logic                     rst_n;
    logic                     mispredict;
    logic                     stall;
    rename_req_t  [LANES-1:0] rename_reqs;
    retire_t      [LANES-1:0] retires;
    rename_resp_t [LANES-1:0] rename_resps;

    // Parsed stimulus, NUM_FIELDS ints per line
    string       test_names[$];
    int          fields_q[$];
    int          num_lines;
    logic        stim_loaded;
    logic        load_failed;
    string       cur_test;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] rng_state;

    rename_core #(.NUM_LANES(LANES)) i_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .rename_reqs (rename_reqs),
        .retires     (retires),
        .mispredict  (mispredict),
        .rename_resps(rename_resps),
        .stall       (stall)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift_step(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_stim();
        int    fd;
        int    code;
        int    value;
        int    c;
        string word;
        fd = $fopen("test/rename_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/rename_stim.txt");
            load_failed = 1'b1;
            return;
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word.getc(0) == "#") begin
                // Skip rest of a comment line
                c = 0;
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                test_names.push_back(word);
                for (int i = 0; i < NUM_FIELDS; i++) begin
                    value = 0;
                    code  = $fscanf(fd, "%d", value);
                    if (code != 1) begin
                        load_failed = 1'b1;
                    end
                    fields_q.push_back(value);
                end
            end
        end
        $fclose(fd);
        if (load_failed) begin
            $display("Stimulus file has a line with missing or bad fields");
        end
    endtask

    task automatic check_field(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error: test %s, %s: expected %0d, actual %0d",
                     cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // Expected fields of a line belong to the request line before it
    task automatic check_resps(input int idx);
        int b;
        for (int k = 0; k < LANES; k++) begin
            b = idx * NUM_FIELDS + 18 + 6 * k;
            check_field($sformatf("lane%0d valid", k), fields_q[b], rename_resps[k].valid);
            // Payload only matters for a valid response
            if (fields_q[b] != 0) begin
                check_field($sformatf("lane%0d has_dest", k), fields_q[b + 1],
                            rename_resps[k].has_dest);
                check_field($sformatf("lane%0d prs1", k), fields_q[b + 2],
                            rename_resps[k].prs1);
                check_field($sformatf("lane%0d prs2", k), fields_q[b + 3],
                            rename_resps[k].prs2);
                check_field($sformatf("lane%0d prd", k), fields_q[b + 4],
                            rename_resps[k].prd);
                check_field($sformatf("lane%0d old_prd", k), fields_q[b + 5],
                            rename_resps[k].old_prd);
            end
        end
    endtask

    task automatic drive_line(input int idx);
        int b;
        b = idx * NUM_FIELDS;
        for (int k = 0; k < LANES; k++) begin
            rename_reqs[k].valid   = 1'(fields_q[b + 5 * k]);
            rename_reqs[k].uses_rd = 1'(fields_q[b + 5 * k + 1]);
            rename_reqs[k].rd      = arch_reg_t'(fields_q[b + 5 * k + 2]);
            rename_reqs[k].rs1     = arch_reg_t'(fields_q[b + 5 * k + 3]);
            rename_reqs[k].rs2     = arch_reg_t'(fields_q[b + 5 * k + 4]);
            retires[k].valid       = 1'(fields_q[b + 10 + 3 * k]);
            retires[k].rd          = arch_reg_t'(fields_q[b + 11 + 3 * k]);
            retires[k].prd         = phys_tag_t'(fields_q[b + 12 + 3 * k]);
        end
        mispredict = 1'(fields_q[b + 16]);
    endtask

    task automatic drive_idle();
        rename_reqs = '0;
        retires     = '0;
        mispredict  = 1'b0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: pass", cur_test);
        end else begin
            $display("Test %s: FAIL with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int gap;
        rst_n        = 1'b0;
        stim_loaded  = 1'b0;
        load_failed  = 1'b0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rng_state    = 32'h4ef3;
        drive_idle();
        load_stim();
        num_lines   = test_names.size();
        stim_loaded = 1'b1;

        // Reset held for RESET_CYCLES rising edges
        cur_test = "reset";
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        check_field("stall", 0, stall);
        for (int k = 0; k < LANES; k++) begin
            check_field($sformatf("lane%0d valid", k), 0, rename_resps[k].valid);
        end
        finish_test();

        for (int i = 0; i < num_lines; i++) begin
            if (i > 0 && test_names[i] != test_names[i - 1]) begin
                finish_test();
                // Idle cycles between tests, no request in flight
                rng_state = xorshift_step(rng_state);
                gap       = rng_state % 2;
                drive_idle();
                repeat (gap) @(negedge clock);
            end
            cur_test = test_names[i];
            check_resps(i);
            drive_line(i);
            // Stall is combinational on this line's inputs
            #1;
            check_field("stall", fields_q[i * NUM_FIELDS + 17], stall);
            @(negedge clock);
        end
        if (num_lines > 0) begin
            finish_test();
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && !load_failed && num_lines > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the stim length
    initial begin
        wait (stim_loaded);
        #((num_lines + RESET_CYCLES + 20) * PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* test/rename_stim.txt */
# name | lane0 req: v uses_rd rd rs1 rs2 | lane1 req | ret0: v rd prd | ret1 | mispredict stall
# then expected resp of the previous line, per lane: v has_dest prs1 prs2 prd old_prd
reset_map    1 1 1 3 4    1 1 2 5 6    0 0 0  0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
reset_map    0 0 0 0 0    0 0 0 0 0    0 0 0  0 0 0   0 0   1 1 3 4 32 1     1 1 5 6 33 2
bypass       1 1 7 1 2    1 1 8 7 1    0 0 0  0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
bypass       1 1 9 0 0    1 1 9 9 8    0 0 0  0 0 0   0 0   1 1 32 33 34 7   1 1 34 32 35 8
bypass       1 1 10 9 7   0 0 0 0 0    0 0 0  0 0 0   0 0   1 1 0 0 36 9     1 1 36 35 37 36
bypass       0 0 0 0 0    0 0 0 0 0    0 0 0  0 0 0   0 0   1 1 37 34 38 10  0 0 0 0 0 0
no_dest      1 1 0 1 2    1 0 5 7 0    0 0 0  0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
no_dest      1 0 3 3 3    1 1 11 3 10  0 0 0  0 0 0   0 0   1 0 32 33 0 0    1 0 34 0 0 0
no_dest      0 0 0 0 0    0 0 0 0 0    0 0 0  0 0 0   0 0   1 0 3 3 0 0      1 1 3 38 39 11
drain        1 1 12 0 0   1 1 13 0 0   0 0 0  0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
drain        1 1 14 0 0   1 1 15 0 0   0 0 0  0 0 0   0 0   1 1 0 0 40 12    1 1 0 0 41 13
drain        1 1 16 0 0   1 1 17 0 0   0 0 0  0 0 0   0 0   1 1 0 0 42 14    1 1 0 0 43 15
drain        1 1 18 0 0   1 1 19 0 0   0 0 0  0 0 0   0 0   1 1 0 0 44 16    1 1 0 0 45 17
drain        1 1 20 0 0   1 1 21 0 0   0 0 0  0 0 0   0 0   1 1 0 0 46 18    1 1 0 0 47 19
drain        1 1 22 0 0   1 1 23 0 0   0 0 0  0 0 0   0 0   1 1 0 0 48 20    1 1 0 0 49 21
drain        1 1 24 0 0   1 1 25 0 0   0 0 0  0 0 0   0 0   1 1 0 0 50 22    1 1 0 0 51 23
drain        1 1 26 0 0   1 1 27 0 0   0 0 0  0 0 0   0 0   1 1 0 0 52 24    1 1 0 0 53 25
drain        1 1 28 0 0   1 1 29 0 0   0 0 0  0 0 0   0 0   1 1 0 0 54 26    1 1 0 0 55 27
drain        1 1 30 0 0   1 1 31 0 0   0 0 0  0 0 0   0 0   1 1 0 0 56 28    1 1 0 0 57 29
drain        1 1 12 0 0   1 1 13 0 0   0 0 0  0 0 0   0 0   1 1 0 0 58 30    1 1 0 0 59 31
drain        1 1 14 0 0   1 1 15 0 0   0 0 0  0 0 0   0 0   1 1 0 0 60 40    1 1 0 0 61 41
drain        0 0 0 0 0    0 0 0 0 0    0 0 0  0 0 0   0 0   1 1 0 0 62 42    1 1 0 0 63 43
retire_free  0 0 0 0 0    0 0 0 0 0    1 7 34 0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
retire_free  1 1 3 7 12   1 0 0 11 9   0 0 0  0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
retire_free  0 0 0 0 0    0 0 0 0 0    0 0 0  0 0 0   0 0   1 1 34 60 7 3    1 0 39 37 0 0
stall        1 1 16 3 16  1 1 17 16 0  0 0 0  0 0 0   0 1   0 0 0 0 0 0      0 0 0 0 0 0
stall        1 1 16 3 16  1 1 17 16 0  1 1 32 0 0 0   0 1   0 0 0 0 0 0      0 0 0 0 0 0
stall        1 1 16 3 16  1 1 17 16 0  0 0 0  0 0 0   0 1   0 0 0 0 0 0      0 0 0 0 0 0
stall        1 1 16 3 16  1 1 17 16 0  0 0 0  1 2 33  0 1   0 0 0 0 0 0      0 0 0 0 0 0
stall        1 1 16 3 16  1 1 17 16 0  0 0 0  0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
stall        0 0 0 0 0    0 0 0 0 0    0 0 0  0 0 0   0 0   1 1 7 44 1 44    1 1 1 0 2 45
mispredict   1 0 0 9 0    0 0 0 0 0    1 9 36 1 9 37  1 0   0 0 0 0 0 0      0 0 0 0 0 0
mispredict   1 1 4 9 7    1 1 5 16 17  0 0 0  0 0 0   0 0   0 0 0 0 0 0      0 0 0 0 0 0
mispredict   1 1 6 1 2    1 1 11 3 11  0 0 0  0 0 0   0 0   1 1 37 34 1 4    1 1 16 17 2 5
mispredict   0 0 0 0 0    0 0 0 0 0    0 0 0  0 0 0   0 0   1 1 32 33 7 6    1 1 3 11 9 11

/* all.f */
rtl/rename_pkg.sv
rtl/spec_map_table.sv
rtl/free_list.sv
rtl/rename_bundle.sv
rtl/arch_map_table.sv
rtl/rename_core.sv
test/rename_core_tb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  # RTL in compile order
  - files:
      - rtl/rename_pkg.sv
      - rtl/spec_map_table.sv
      - rtl/free_list.sv
      - rtl/rename_bundle.sv
      - rtl/arch_map_table.sv
      - rtl/rename_core.sv

  # Testbench
  - target: test
    files:
      - test/rename_core_tb.sv
